/* hdl/vdma_geom_pkg.sv */
`default_nettype none

package vdma_geom_pkg;

    // frame geometry
    localparam int PIXEL_W         = 32;
    localparam int X_DIV           = 2;     // bursts per line
    localparam int X_STRIDE        = 1920;  // line pitch in pixels
    localparam int BUF_COUNT       = 3;
    localparam int FIFO_RST_CYCLES = 16;

    // offset within one frame buffer, 32-bit units
    localparam int OFFSET_W        = 22;
    localparam int BUF_IDX_W       = 3;

    typedef logic [PIXEL_W-1:0]   pixel_t;

    typedef logic [9:0]           xsize_t;   // pixels per line
    typedef logic [9:0]           ysize_t;   // lines per frame

    typedef logic [OFFSET_W-1:0]  offset_t;
    typedef logic [BUF_IDX_W-1:0] buf_idx_t;

    typedef logic [7:0]           frame_cnt_t;

endpackage

`default_nettype wire

/* hdl/vdma_bus_pkg.sv */
`default_nettype none

package vdma_bus_pkg;

    localparam int BUS_W        = 128;
    localparam int ADDR_W       = 28;
    localparam int PIX_PER_WORD = 4;    // 32-bit pixels in one bus word

    // write FIFO, counted in bus words
    localparam int FIFO_DEPTH   = 64;
    localparam int LEVEL_W      = 7;    // holds 0 .. FIFO_DEPTH

    typedef logic [BUS_W-1:0]   bus_word_t;
    typedef logic [ADDR_W-1:0]  dma_addr_t;
    typedef logic [15:0]        burst_len_t;
    typedef logic [LEVEL_W-1:0] level_t;

    // write channel states
    typedef enum logic [1:0] {
        ch_idle,
        ch_rst,     // FIFO held in reset
        ch_req,     // request raised, waiting for busy
        ch_wait     // burst in flight
    } ch_state_t;

endpackage

`default_nettype wire

/* hdl/addr_step_if.sv */
`default_nettype none

interface addr_step_if import vdma_geom_pkg::*; ();

    logic     clear;      // new frame, offset back to 0
    logic     load_buf;
    buf_idx_t buf_idx;
    logic     step;       // one burst done, move on
    xsize_t   x_size;

    modport ctrl (
        output clear,
        output load_buf,
        output buf_idx,
        output step,
        output x_size
    );

    modport gen (
        input clear,
        input load_buf,
        input buf_idx,
        input step,
        input x_size
    );

endinterface

`default_nettype wire

/* hdl/frame_sync_detect.sv */
`default_nettype none

module frame_sync_detect (
    input  logic ui_clk,
    input  logic ui_rstn,
    input  logic fs_i,
    output logic fs_pulse_o
);

    logic [1:0] fs_sync;  // two flops, fs_i may come from another clock
    logic       fs_prev;

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn) begin
            fs_sync    <= 2'b00;
            fs_prev    <= 1'b0;
            fs_pulse_o <= 1'b0;
        end else begin
            fs_sync    <= {fs_sync[0], fs_i};
            fs_prev    <= fs_sync[1];
            fs_pulse_o <= fs_sync[1] & ~fs_prev;  // rising edge only
        end
    end

endmodule

`default_nettype wire

/* hdl/burst_addr_gen.sv */
`default_nettype none

module burst_addr_gen
    import vdma_geom_pkg::*;
    import vdma_bus_pkg::*;
(
    input  logic        ui_clk,
    input  logic        ui_rstn,
    addr_step_if.gen    step_if,
    input  dma_addr_t   base_addr_i,
    output dma_addr_t   burst_addr_o
);

    buf_idx_t buf_q;
    offset_t  offset;
    logic [$clog2(X_DIV)-1:0] div_cnt;  // which part of the line

    offset_t x_words;
    offset_t half_inc;
    offset_t line_inc;

    // line length in 32-bit units
    assign x_words  = offset_t'(32'(step_if.x_size) * (PIXEL_W / 32));
    assign half_inc = offset_t'(x_words / X_DIV);
    // last part of a line also skips the stride remainder
    assign line_inc = offset_t'(X_STRIDE * (PIXEL_W / 32)) - x_words + half_inc;

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn) begin
            buf_q   <= '0;
            offset  <= '0;
            div_cnt <= '0;
        end else begin
            if (step_if.load_buf)
                buf_q <= step_if.buf_idx;

            if (step_if.clear) begin
                offset  <= '0;
                div_cnt <= '0;
            end else if (step_if.step) begin
                if (div_cnt == X_DIV - 1) begin
                    offset  <= offset + line_inc;
                    div_cnt <= '0;
                end else begin
                    offset  <= offset + half_inc;
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    // buffer index sits just above the offset bits
    assign burst_addr_o = base_addr_i + dma_addr_t'({buf_q, offset});

endmodule

`default_nettype wire

/* hdl/line_pack_fifo.sv */
`default_nettype none

module line_pack_fifo
    import vdma_geom_pkg::*;
    import vdma_bus_pkg::*;
(
    input  logic      ui_clk,
    input  logic      ui_rstn,
    input  logic      fifo_rst_i,
    input  logic      pix_we_i,
    input  pixel_t    pix_i,
    output logic      full_o,
    input  logic      pop_i,
    output bus_word_t word_o,
    output level_t    level_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    bus_word_t mem [FIFO_DEPTH];

    bus_word_t pack_sr;
    bus_word_t pack_word;
    logic [$clog2(PIX_PER_WORD)-1:0] pix_cnt;

    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    level_t           level;

    logic accept;
    logic push;
    logic pop;

    assign full_o = (level == level_t'(FIFO_DEPTH));

    // writes while full or in reset are dropped
    assign accept = pix_we_i && !full_o && !fifo_rst_i;
    assign push   = accept && (pix_cnt == PIX_PER_WORD - 1);
    assign pop    = pop_i && (level != '0) && !fifo_rst_i;

    // new pixel enters at the top, first pixel ends up lowest
    assign pack_word = {pix_i, pack_sr[BUS_W-1:PIXEL_W]};

    always_ff @(posedge ui_clk) begin
        if (accept)
            pack_sr <= pack_word;
        if (push)
            mem[wptr] <= pack_word;
    end

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn || fifo_rst_i) begin
            pix_cnt <= '0;
            wptr    <= '0;
            rptr    <= '0;
            level   <= '0;
        end else begin
            if (accept)
                pix_cnt <= pix_cnt + 1'b1;  // wraps after the fourth pixel
            if (push)
                wptr <= wptr + 1'b1;
            if (pop)
                rptr <= rptr + 1'b1;

            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign word_o  = mem[rptr];  // show-ahead
    assign level_o = level;

endmodule

`default_nettype wire

/* hdl/wr_frame_ctrl.sv */
`default_nettype none

module wr_frame_ctrl
    import vdma_geom_pkg::*;
    import vdma_bus_pkg::*;
(
    input  logic        ui_clk,
    input  logic        ui_rstn,
    input  logic        fs_pulse_i,
    input  ysize_t      y_size_i,
    input  xsize_t      x_size_i,
    input  buf_idx_t    buf_i,
    input  level_t      level_i,
    input  logic        busy_i,
    addr_step_if.ctrl   step_if,
    output logic        fifo_rst_o,
    output logic        req_o,
    output burst_len_t  burst_len_o,
    output frame_cnt_t  frame_cnt_o
);

    ch_state_t state;

    logic [$clog2(FIFO_RST_CYCLES)-1:0] rst_cnt;
    logic [$clog2(X_DIV)-1:0]           div_cnt;
    ysize_t                             line_cnt;
    logic                               last_burst;

    // half a line of pixels in bus words
    assign burst_len_o = burst_len_t'((32'(x_size_i) * PIXEL_W) / (BUS_W * X_DIV));

    assign last_burst = (line_cnt == y_size_i - 1'b1) && (div_cnt == X_DIV - 1);

    assign step_if.buf_idx = buf_i;
    assign step_if.x_size  = x_size_i;

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn) begin
            state            <= ch_idle;
            rst_cnt          <= '0;
            div_cnt          <= '0;
            line_cnt         <= '0;
            fifo_rst_o       <= 1'b0;
            req_o            <= 1'b0;
            frame_cnt_o      <= '0;
            step_if.clear    <= 1'b0;
            step_if.load_buf <= 1'b0;
            step_if.step     <= 1'b0;
        end else begin
            step_if.clear    <= 1'b0;
            step_if.load_buf <= 1'b0;
            step_if.step     <= 1'b0;

            case (state)
                ch_idle: begin
                    // frame sync only honoured here
                    if (fs_pulse_i) begin
                        state            <= ch_rst;
                        fifo_rst_o       <= 1'b1;
                        rst_cnt          <= '0;
                        div_cnt          <= '0;
                        line_cnt         <= '0;
                        step_if.clear    <= 1'b1;
                        step_if.load_buf <= 1'b1;
                        if (frame_cnt_o == frame_cnt_t'(BUF_COUNT - 1))
                            frame_cnt_o <= '0;
                        else
                            frame_cnt_o <= frame_cnt_o + 1'b1;
                    end
                end

                ch_rst: begin
                    rst_cnt <= rst_cnt + 1'b1;
                    if (rst_cnt == FIFO_RST_CYCLES - 1) begin
                        fifo_rst_o <= 1'b0;
                        state      <= ch_req;
                    end
                end

                ch_req: begin
                    if (busy_i) begin
                        req_o <= 1'b0;  // engine took it
                        state <= ch_wait;
                    end else if (burst_len_t'(level_i) >= burst_len_o) begin
                        req_o <= 1'b1;
                    end
                end

                ch_wait: begin
                    if (!busy_i) begin
                        if (last_burst) begin
                            state <= ch_idle;
                        end else begin
                            state        <= ch_req;
                            step_if.step <= 1'b1;
                            if (div_cnt == X_DIV - 1) begin
                                div_cnt  <= '0;
                                line_cnt <= line_cnt + 1'b1;
                            end else begin
                                div_cnt <= div_cnt + 1'b1;
                            end
                        end
                    end
                end

                default: state <= ch_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/vdma_wr_top.sv */
`default_nettype none

module vdma_wr_top
    import vdma_geom_pkg::*;
    import vdma_bus_pkg::*;
(
    input  logic        ui_clk,
    input  logic        ui_rstn,
    input  logic        frame_sync_i,
    // pixel side
    input  logic        pix_we_i,
    input  pixel_t      pix_i,
    output logic        pix_full_o,
    // frame setup
    input  xsize_t      x_size_i,
    input  ysize_t      y_size_i,
    input  dma_addr_t   base_addr_i,
    input  buf_idx_t    buf_i,
    output frame_cnt_t  frame_cnt_o,
    // DMA engine
    output logic        dma_req_o,
    output dma_addr_t   dma_addr_o,
    output burst_len_t  dma_len_o,
    input  logic        dma_busy_i,
    input  logic        dma_valid_i,
    output bus_word_t   dma_data_o
);

    logic   fs_pulse;
    logic   fifo_rst;
    level_t fifo_level;

    addr_step_if u_step_if ();

    frame_sync_detect u_fs_detect (
        .ui_clk     (ui_clk),
        .ui_rstn    (ui_rstn),
        .fs_i       (frame_sync_i),
        .fs_pulse_o (fs_pulse)
    );

    line_pack_fifo u_pack_fifo (
        .ui_clk     (ui_clk),
        .ui_rstn    (ui_rstn),
        .fifo_rst_i (fifo_rst),
        .pix_we_i   (pix_we_i),
        .pix_i      (pix_i),
        .full_o     (pix_full_o),
        .pop_i      (dma_valid_i),  // one word per valid
        .word_o     (dma_data_o),
        .level_o    (fifo_level)
    );

    wr_frame_ctrl u_frame_ctrl (
        .ui_clk      (ui_clk),
        .ui_rstn     (ui_rstn),
        .fs_pulse_i  (fs_pulse),
        .y_size_i    (y_size_i),
        .x_size_i    (x_size_i),
        .buf_i       (buf_i),
        .level_i     (fifo_level),
        .busy_i      (dma_busy_i),
        .step_if     (u_step_if.ctrl),
        .fifo_rst_o  (fifo_rst),
        .req_o       (dma_req_o),
        .burst_len_o (dma_len_o),
        .frame_cnt_o (frame_cnt_o)
    );

    burst_addr_gen u_addr_gen (
        .ui_clk       (ui_clk),
        .ui_rstn      (ui_rstn),
        .step_if      (u_step_if.gen),
        .base_addr_i  (base_addr_i),
        .burst_addr_o (dma_addr_o)
    );

endmodule

`default_nettype wire

/* tb/tb_vdma_tasks.svh */
task automatic tick();
    @(posedge ui_clk);
    #1;  // inputs change just after the edge
endtask

task automatic report_mismatch(input string name, input logic [127:0] got,
                               input logic [127:0] exp_val);
    err_cnt++;
    $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp_val);
endtask

task automatic report_timeout(input string what);
    err_cnt++;
    $display("timeout while waiting, %s", what);
endtask

// address of burst n within a frame
function automatic dma_addr_t expected_addr(input int n);
    int off;
    int k;
    off = 0;
    for (k = 1; k <= n; k++) begin
        if (k % X_DIV == 0)
            off += X_STRIDE - int'(X_SIZE) + int'(X_SIZE) / X_DIV;  // line end
        else
            off += int'(X_SIZE) / X_DIV;
    end
    return BASE + (dma_addr_t'(BUF_SEL) << OFFSET_W) + dma_addr_t'(off);
endfunction

function automatic bus_word_t expected_word(input int p);
    bus_word_t w;
    int k;
    for (k = 0; k < PIX_PER_WORD; k++)
        w[k*PIXEL_W +: PIXEL_W] = sent_q[p + k];  // first pixel lowest
    return w;
endfunction

task automatic write_pixels(input int n);
    pixel_t p;
    repeat (n) begin
        p      = $urandom();
        pix_we = 1'b1;
        pix    = p;
        sent_q.push_back(p);
        tick();
    end
    pix_we = 1'b0;
endtask

// pops words straight from the FIFO while no frame runs
task automatic drain_words(input int n, input int p0);
    int w;
    bus_word_t exp_word;
    for (w = 0; w < n; w++) begin
        drain_valid = 1'b1;
        #1;
        exp_word = expected_word(p0 + w * PIX_PER_WORD);
        if (dma_data !== exp_word)
            report_mismatch("dma_data_o", dma_data, exp_word);
        tick();
    end
    drain_valid = 1'b0;
endtask

task automatic check_after_reset();
    if (dma_req !== 1'b0)
        report_mismatch("dma_req_o", dma_req, 0);
    if (pix_full !== 1'b0)
        report_mismatch("pix_full_o", pix_full, 0);
    if (frame_cnt !== '0)
        report_mismatch("frame_cnt_o", frame_cnt, 0);
endtask

task automatic run_frame(input frame_cnt_t exp_cnt, input bit gate_check);
    int b0;
    int w0;
    int p0;
    int sent;
    int cycles;
    int i;
    b0   = addr_q.size();
    w0   = data_q.size();
    p0   = sent_q.size();
    sent = 0;
    frame_sync = 1'b1;
    repeat (4) tick();
    frame_sync = 1'b0;
    repeat (FIFO_RST_CYCLES + 2) tick();  // sync pulse delay and FIFO reset hold
    if (frame_cnt !== exp_cnt)
        report_mismatch("frame_cnt_o", frame_cnt, exp_cnt);
    if (gate_check) begin
        write_pixels(BURST_PIX - 1);
        repeat (6) begin
            if (dma_req !== 1'b0)
                report_mismatch("dma_req_o", dma_req, 0);
            tick();
        end
        write_pixels(1);
        cycles = 0;
        while (dma_req !== 1'b1 && cycles < 20) begin
            tick();
            cycles++;
        end
        if (dma_req !== 1'b1) begin
            report_timeout("no request after a full burst of pixels");
            return;
        end
        sent = BURST_PIX;
    end
    write_pixels(FRAME_PIX - sent);
    cycles = 0;
    while (bursts_done < b0 + FRAME_BURSTS && cycles < 400) begin
        tick();
        cycles++;
    end
    if (bursts_done < b0 + FRAME_BURSTS) begin
        report_timeout("the bursts of a frame did not complete");
        return;
    end
    repeat (2) tick();  // controller back in idle
    if (addr_q.size() != b0 + FRAME_BURSTS || data_q.size() != w0 + FRAME_WORDS) begin
        err_cnt++;
        $display("frame %0d moved a wrong number of bursts or words", exp_cnt);
    end else begin
        for (i = 0; i < FRAME_BURSTS; i++) begin
            if (addr_q[b0 + i] !== expected_addr(i))
                report_mismatch("dma_addr_o", addr_q[b0 + i], expected_addr(i));
            if (len_q[b0 + i] !== burst_len_t'(BURST_WORDS))
                report_mismatch("dma_len_o", len_q[b0 + i], BURST_WORDS);
        end
        for (i = 0; i < FRAME_WORDS; i++) begin
            if (data_q[w0 + i] !== expected_word(p0 + i * PIX_PER_WORD))
                report_mismatch("dma_data_o", data_q[w0 + i],
                                expected_word(p0 + i * PIX_PER_WORD));
        end
    end
endtask

task automatic check_full_drop();
    int p0;
    p0 = sent_q.size();
    write_pixels(FIFO_DEPTH * PIX_PER_WORD - PIX_PER_WORD);
    if (pix_full !== 1'b0)
        report_mismatch("pix_full_o", pix_full, 0);
    write_pixels(PIX_PER_WORD);
    if (pix_full !== 1'b1)
        report_mismatch("pix_full_o", pix_full, 1);
    write_pixels(2 * PIX_PER_WORD);  // dropped while full
    drain_words(FIFO_DEPTH, p0);
    if (pix_full !== 1'b0)
        report_mismatch("pix_full_o", pix_full, 0);
    // packer still aligned after the dropped writes
    p0 = sent_q.size();
    write_pixels(PIX_PER_WORD);
    drain_words(1, p0);
endtask

/* tb/tb_vdma_wr.sv */
`default_nettype none

module tb_vdma_wr
    import vdma_geom_pkg::*;
    import vdma_bus_pkg::*;
();

    localparam int        SEED         = 32'h4fa8_097e;
    localparam xsize_t    X_SIZE       = 10'd16;
    localparam ysize_t    Y_SIZE       = 10'd2;
    localparam dma_addr_t BASE         = 28'h012_3400;
    localparam buf_idx_t  BUF_SEL      = 3'd2;
    localparam int        FRAME_PIX    = int'(X_SIZE) * int'(Y_SIZE);
    localparam int        FRAME_BURSTS = X_DIV * int'(Y_SIZE);  // two per line
    localparam int        FRAME_WORDS  = FRAME_PIX / PIX_PER_WORD;
    localparam int        BURST_WORDS  = int'(X_SIZE) * PIXEL_W / BUS_W / X_DIV;
    localparam int        BURST_PIX    = BURST_WORDS * PIX_PER_WORD;

    logic       ui_clk = 1'b0;
    logic       ui_rstn;
    logic       frame_sync;
    logic       pix_we;
    pixel_t     pix;
    logic       pix_full;
    frame_cnt_t frame_cnt;
    logic       dma_req;
    dma_addr_t  dma_addr;
    burst_len_t dma_len;
    logic       dma_busy    = 1'b0;
    logic       model_valid = 1'b0;
    logic       drain_valid;
    logic       dma_valid;
    bus_word_t  dma_data;

    int err_cnt     = 0;
    int bursts_done = 0;

    pixel_t     sent_q[$];  // every pixel driven in order
    dma_addr_t  addr_q[$];
    burst_len_t len_q[$];
    bus_word_t  data_q[$];

    always #2 ui_clk = ~ui_clk;

    assign dma_valid = model_valid | drain_valid;

    vdma_wr_top dut (
        .ui_clk       (ui_clk),
        .ui_rstn      (ui_rstn),
        .frame_sync_i (frame_sync),
        .pix_we_i     (pix_we),
        .pix_i        (pix),
        .pix_full_o   (pix_full),
        .x_size_i     (X_SIZE),
        .y_size_i     (Y_SIZE),
        .base_addr_i  (BASE),
        .buf_i        (BUF_SEL),
        .frame_cnt_o  (frame_cnt),
        .dma_req_o    (dma_req),
        .dma_addr_o   (dma_addr),
        .dma_len_o    (dma_len),
        .dma_busy_i   (dma_busy),
        .dma_valid_i  (dma_valid),
        .dma_data_o   (dma_data)
    );

    // DMA engine raises busy one cycle after the request and then gives one valid per word
    always begin
        int i;
        @(posedge ui_clk);
        #1;
        if (dma_req && !dma_busy) begin
            addr_q.push_back(dma_addr);
            len_q.push_back(dma_len);
            dma_busy = 1'b1;
            for (i = 0; i < int'(dma_len); i++) begin
                @(posedge ui_clk);
                #1;
                model_valid = 1'b1;
                #1;
                data_q.push_back(dma_data);  // show-ahead word of this cycle
            end
            @(posedge ui_clk);
            #1;
            model_valid = 1'b0;
            dma_busy    = 1'b0;
            bursts_done++;
        end
    end

    `include "tb_vdma_tasks.svh"

    initial begin
        void'($urandom(SEED));
        ui_rstn     = 1'b0;
        frame_sync  = 1'b0;
        pix_we      = 1'b0;
        pix         = '0;
        drain_valid = 1'b0;
        repeat (3) @(posedge ui_clk);
        #1;
        ui_rstn = 1'b1;

        check_after_reset();
        run_frame(8'd1, 1'b1);  // first frame also checks request gating
        run_frame(8'd2, 1'b0);
        run_frame(8'd0, 1'b0);
        run_frame(8'd1, 1'b0);
        check_full_drop();

        $display("tests finished, %0d errors", err_cnt);
        if (err_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+tb
hdl/vdma_geom_pkg.sv
hdl/vdma_bus_pkg.sv
hdl/addr_step_if.sv
hdl/frame_sync_detect.sv
hdl/burst_addr_gen.sv
hdl/line_pack_fifo.sv
hdl/wr_frame_ctrl.sv
hdl/vdma_wr_top.sv
tb/tb_vdma_wr.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_vdma_wr -o sim_vdma_wr
./obj_dir/sim_vdma_wr | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
